/* hw/pkt_mon_pkg.sv */
////////////////////////////////////////////////////////////
// Packet monitor shared constants: stream widths,
// expected table sizes and CRC-16 parameters
////////////////////////////////////////////////////////////
`default_nettype none

package pkt_mon_pkg;

    ////////////////////////////////////////////////////////////
    // Stream

    // Byte lanes per beat
    localparam int DATA_BYTES = 4;
    localparam int DATA_W     = DATA_BYTES * 8;

    // Destination field and reassembly contexts
    localparam int DEST_W    = 2;
    localparam int NUM_DESTS = 4;

    // Largest packet, and the width that can hold it
    localparam int MTU_BYTES = 256;
    localparam int BLEN_W    = 9;

    ////////////////////////////////////////////////////////////
    // Signature

    localparam int SIG_W = 16;

    // CRC-16-CCITT, MSB first, no reflection, no final XOR
    localparam logic [SIG_W-1:0] SIG_INIT = 16'hffff;
    localparam logic [SIG_W-1:0] SIG_POLY = 16'h1021;

    ////////////////////////////////////////////////////////////
    // Expected packet table

    localparam int NUM_EXPECTED = 8;
    localparam int EXP_IDX_W    = 3;

    // Counts 0 to NUM_EXPECTED inclusive
    localparam int PEND_W = 4;

endpackage

`default_nettype wire

/* hw/stream_beat_if.sv */
////////////////////////////////////////////////////////////
// One accepted stream beat, fanned out to the measuring blocks
////////////////////////////////////////////////////////////
`default_nettype none

interface stream_beat_if import pkt_mon_pkg::*; ();

    // High for one cycle per accepted beat, no ready
    logic                  beat_valid;
    logic [DATA_W-1:0]     data;
    // Lane 0 holds the first byte of the beat
    logic [DATA_BYTES-1:0] keep;
    logic                  last;
    logic [DEST_W-1:0]     dest;

    modport src (
        output beat_valid,
        output data,
        output keep,
        output last,
        output dest
    );

    modport sink (
        input beat_valid,
        input data,
        input keep,
        input last,
        input dest
    );

endinterface

`default_nettype wire

/* hw/pkt_length_counter.sv */
////////////////////////////////////////////////////////////
// Per-destination byte counter, reports packet length
////////////////////////////////////////////////////////////
`default_nettype none

module pkt_length_counter import pkt_mon_pkg::*; (
    input  logic              axis_packet_in,
    input  logic              arst_n,
    stream_beat_if.sink       beat,
    output logic              len_valid,
    output logic [DEST_W-1:0] len_dest,
    output logic [BLEN_W-1:0] len_blen
);

    // Number of kept lanes in a beat
    function automatic logic [BLEN_W-1:0] keep_bytes(input logic [DATA_BYTES-1:0] keep);
        logic [BLEN_W-1:0] n;
        n = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            n = n + BLEN_W'(keep[i]);
        end
        return n;
    endfunction

    // Running count, one per destination context
    logic [BLEN_W-1:0] cnt_q [NUM_DESTS];
    logic [BLEN_W-1:0] cnt_sum;

    assign cnt_sum = cnt_q[beat.dest] + keep_bytes(beat.keep);

    ////////////////////////////////////////////////////////////
    // Context update

    always_ff @(posedge axis_packet_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int d = 0; d < NUM_DESTS; d++) begin
                cnt_q[d] <= '0;
            end
            len_valid <= 1'b0;
        end else begin
            len_valid <= beat.beat_valid && beat.last;
            if (beat.beat_valid) begin
                // Last beat closes the context for the next packet
                if (beat.last) begin
                    cnt_q[beat.dest] <= '0;
                end else begin
                    cnt_q[beat.dest] <= cnt_sum;
                end
            end
        end
    end

    // Result payload, qualified by len_valid
    always_ff @(posedge axis_packet_in) begin
        if (beat.beat_valid && beat.last) begin
            len_blen <= cnt_sum;
            len_dest <= beat.dest;
        end
    end

endmodule

`default_nettype wire

/* hw/pkt_signature.sv */
////////////////////////////////////////////////////////////
// Per-destination CRC-16 over the kept bytes of each packet
////////////////////////////////////////////////////////////
`default_nettype none

module pkt_signature import pkt_mon_pkg::*; (
    input  logic             axis_packet_in,
    input  logic             arst_n,
    stream_beat_if.sink      beat,
    output logic             sig_valid,
    output logic [SIG_W-1:0] sig_value
);

    // One byte into the CRC, MSB first
    function automatic logic [SIG_W-1:0] crc_byte_step(
        input logic [SIG_W-1:0] crc_in,
        input logic [7:0]       byte_in
    );
        logic [SIG_W-1:0] c;
        c = crc_in ^ (SIG_W'(byte_in) << (SIG_W - 8));
        for (int k = 0; k < 8; k++) begin
            if (c[SIG_W-1]) begin
                c = (c << 1) ^ SIG_POLY;
            end else begin
                c = c << 1;
            end
        end
        return c;
    endfunction

    logic [SIG_W-1:0] crc_q [NUM_DESTS];
    logic [SIG_W-1:0] crc_next;

    ////////////////////////////////////////////////////////////
    // Fold the beat into its context

    always_comb begin
        crc_next = crc_q[beat.dest];
        // Lane order, skipping lanes outside keep
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (beat.keep[i]) begin
                crc_next = crc_byte_step(crc_next, beat.data[i*8 +: 8]);
            end
        end
    end

    always_ff @(posedge axis_packet_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int d = 0; d < NUM_DESTS; d++) begin
                crc_q[d] <= SIG_INIT;
            end
            sig_valid <= 1'b0;
        end else begin
            sig_valid <= beat.beat_valid && beat.last;
            if (beat.beat_valid) begin
                if (beat.last) begin
                    crc_q[beat.dest] <= SIG_INIT;
                end else begin
                    crc_q[beat.dest] <= crc_next;
                end
            end
        end
    end

    // Final signature, lines up with the length result
    always_ff @(posedge axis_packet_in) begin
        if (beat.beat_valid && beat.last) begin
            sig_value <= crc_next;
        end
    end

endmodule

`default_nettype wire

/* hw/pkt_matcher.sv */
////////////////////////////////////////////////////////////
// Expected packet table, matches each summary to an entry
// and tracks how many entries are still pending
////////////////////////////////////////////////////////////
`default_nettype none

module pkt_matcher import pkt_mon_pkg::*; (
    input  logic                 axis_packet_in,
    input  logic                 arst_n,
    input  logic                 len_valid,
    input  logic [DEST_W-1:0]    len_dest,
    input  logic [BLEN_W-1:0]    len_blen,
    input  logic [SIG_W-1:0]     sig_value,
    input  logic                 exp_wr,
    input  logic [EXP_IDX_W-1:0] exp_index,
    input  logic [DEST_W-1:0]    exp_dest,
    input  logic [BLEN_W-1:0]    exp_blen,
    input  logic [SIG_W-1:0]     exp_sig,
    output logic                 match_valid,
    output logic                 match_hit,
    output logic [EXP_IDX_W-1:0] match_index,
    output logic [DEST_W-1:0]    match_dest,
    output logic [BLEN_W-1:0]    match_blen,
    output logic [PEND_W-1:0]    pending_count
);

    ////////////////////////////////////////////////////////////
    // Table storage

    logic [NUM_EXPECTED-1:0] tbl_valid;
    logic [DEST_W-1:0]       tbl_dest [NUM_EXPECTED];
    logic [BLEN_W-1:0]       tbl_blen [NUM_EXPECTED];
    logic [SIG_W-1:0]        tbl_sig  [NUM_EXPECTED];

    logic                    found;
    logic [EXP_IDX_W-1:0]    found_idx;
    logic                    hit_now;
    logic                    pend_inc;
    logic                    pend_dec;

    always_ff @(posedge axis_packet_in) begin
        if (exp_wr) begin
            tbl_dest[exp_index] <= exp_dest;
            tbl_blen[exp_index] <= exp_blen;
            tbl_sig[exp_index]  <= exp_sig;
        end
    end

    ////////////////////////////////////////////////////////////
    // Priority search, lowest index wins

    always_comb begin
        found     = 1'b0;
        found_idx = '0;
        for (int i = 0; i < NUM_EXPECTED; i++) begin
            if (!found && tbl_valid[i] && tbl_dest[i] == len_dest &&
                tbl_blen[i] == len_blen && tbl_sig[i] == sig_value) begin
                found     = 1'b1;
                found_idx = EXP_IDX_W'(i);
            end
        end
    end

    assign hit_now = len_valid && found;

    // A load into a slot consumed in the same cycle refills an empty slot
    assign pend_inc = exp_wr &&
                      (!tbl_valid[exp_index] || (hit_now && found_idx == exp_index));
    // Count follows the reported hit, one cycle after the valid bit
    assign pend_dec = match_valid && match_hit;

    ////////////////////////////////////////////////////////////
    // Valid bits, report and pending count

    always_ff @(posedge axis_packet_in or negedge arst_n) begin
        if (!arst_n) begin
            tbl_valid     <= '0;
            match_valid   <= 1'b0;
            match_hit     <= 1'b0;
            pending_count <= '0;
        end else begin
            for (int i = 0; i < NUM_EXPECTED; i++) begin
                // Load has priority over consumption
                if (exp_wr && exp_index == EXP_IDX_W'(i)) begin
                    tbl_valid[i] <= 1'b1;
                end else if (hit_now && found_idx == EXP_IDX_W'(i)) begin
                    tbl_valid[i] <= 1'b0;
                end
            end
            match_valid   <= len_valid;
            match_hit     <= hit_now;
            pending_count <= pending_count + PEND_W'(pend_inc) - PEND_W'(pend_dec);
        end
    end

    always_ff @(posedge axis_packet_in) begin
        if (len_valid) begin
            match_index <= found_idx;
            match_dest  <= len_dest;
            match_blen  <= len_blen;
        end
    end

endmodule

`default_nettype wire

/* hw/pkt_monitor_top.sv */
////////////////////////////////////////////////////////////
// Packet monitor top level, length and CRC per packet
// checked against a table of expected packets
////////////////////////////////////////////////////////////
`default_nettype none

module pkt_monitor_top import pkt_mon_pkg::*; (
    input  logic                  axis_packet_in,
    input  logic                  arst_n,
    // Stream in
    input  logic                  tvalid,
    input  logic [DATA_W-1:0]     tdata,
    input  logic [DATA_BYTES-1:0] tkeep,
    input  logic                  tlast,
    input  logic [DEST_W-1:0]     tdest,
    // Table load
    input  logic                  exp_wr,
    input  logic [EXP_IDX_W-1:0]  exp_index,
    input  logic [DEST_W-1:0]     exp_dest,
    input  logic [BLEN_W-1:0]     exp_blen,
    input  logic [SIG_W-1:0]      exp_sig,
    // Match report
    output logic                  match_valid,
    output logic                  match_hit,
    output logic [EXP_IDX_W-1:0]  match_index,
    output logic [DEST_W-1:0]     match_dest,
    output logic [BLEN_W-1:0]     match_blen,
    output logic [PEND_W-1:0]     pending_count
);

    stream_beat_if beat ();

    logic              len_valid;
    logic [DEST_W-1:0] len_dest;
    logic [BLEN_W-1:0] len_blen;
    logic [SIG_W-1:0]  sig_value;

    assign beat.beat_valid = tvalid;
    assign beat.data       = tdata;
    assign beat.keep       = tkeep;
    assign beat.last       = tlast;
    assign beat.dest       = tdest;

    pkt_length_counter u_length (
        .axis_packet_in (axis_packet_in),
        .arst_n         (arst_n),
        .beat           (beat),
        .len_valid      (len_valid),
        .len_dest       (len_dest),
        .len_blen       (len_blen)
    );

    // sig_valid always coincides with len_valid
    pkt_signature u_signature (
        .axis_packet_in (axis_packet_in),
        .arst_n         (arst_n),
        .beat           (beat),
        .sig_valid      (),
        .sig_value      (sig_value)
    );

    pkt_matcher u_matcher (
        .axis_packet_in (axis_packet_in),
        .arst_n         (arst_n),
        .len_valid      (len_valid),
        .len_dest       (len_dest),
        .len_blen       (len_blen),
        .sig_value      (sig_value),
        .exp_wr         (exp_wr),
        .exp_index      (exp_index),
        .exp_dest       (exp_dest),
        .exp_blen       (exp_blen),
        .exp_sig        (exp_sig),
        .match_valid    (match_valid),
        .match_hit      (match_hit),
        .match_index    (match_index),
        .match_dest     (match_dest),
        .match_blen     (match_blen),
        .pending_count  (pending_count)
    );

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
////////////////////////////////////////////////////////////
// Testbench clock and reset source
////////////////////////////////////////////////////////////
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic axis_packet_in,
    output logic arst_n
);

    initial begin
        axis_packet_in = 1'b0;
        forever begin
            #(PERIOD / 2) axis_packet_in = ~axis_packet_in;
        end
    end

    // Release away from the clock edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge axis_packet_in);
        #1;
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/pkt_monitor_checker.sv */
////////////////////////////////////////////////////////////
// Match report checker, compares each report with the queue
////////////////////////////////////////////////////////////
`default_nettype none

module pkt_monitor_checker import pkt_mon_pkg::*; (
    input logic                 axis_packet_in,
    input logic                 match_valid,
    input logic                 match_hit,
    input logic [EXP_IDX_W-1:0] match_index,
    input logic [DEST_W-1:0]    match_dest,
    input logic [BLEN_W-1:0]    match_blen,
    input logic [PEND_W-1:0]    pending_count
);

    localparam int DRAIN_CYCLES = 16;

    typedef struct packed {
        logic                 hit;
        logic [EXP_IDX_W-1:0] index;
        logic [DEST_W-1:0]    dest;
        logic [BLEN_W-1:0]    blen;
    } report_t;

    report_t exp_q [$];
    int      test_num      = 0;
    int      test_reports  = 0;
    int      test_errors   = 0;
    int      total_reports = 0;
    int      error_count   = 0;

    task automatic expect_report(
        input logic                 hit,
        input logic [EXP_IDX_W-1:0] index,
        input logic [DEST_W-1:0]    dest,
        input logic [BLEN_W-1:0]    blen
    );
        exp_q.push_back(report_t'{hit, index, dest, blen});
    endtask

    task automatic report_mismatch(input string what, input int got, input int want);
        $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, want);
        error_count++;
        test_errors++;
    endtask

    ////////////////////////////////////////////////////////////
    // Compare on the falling edge, away from DUT updates

    always @(negedge axis_packet_in) begin
        report_t e;
        if (match_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected match report at time %0t with no packet outstanding",
                         $time);
                error_count++;
                test_errors++;
            end else begin
                e = exp_q.pop_front();
                test_reports++;
                if (match_hit !== e.hit) begin
                    report_mismatch("match_hit", int'(match_hit), int'(e.hit));
                end else if (e.hit && match_index !== e.index) begin
                    report_mismatch("match_index", int'(match_index), int'(e.index));
                end
                if (match_dest !== e.dest) begin
                    report_mismatch("match_dest", int'(match_dest), int'(e.dest));
                end
                if (match_blen !== e.blen) begin
                    report_mismatch("match_blen", int'(match_blen), int'(e.blen));
                end
            end
        end
    end

    // Waits for outstanding reports, then checks the pending count
    task automatic close_test(input string name, input int exp_pending);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(negedge axis_packet_in);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Missing match report: %0d packet(s) got no report within %0d cycles",
                     exp_q.size(), DRAIN_CYCLES);
            error_count += exp_q.size();
            test_errors += exp_q.size();
            exp_q.delete();
        end
        // Pending count moves one cycle after the report
        repeat (2) @(negedge axis_packet_in);
        if (int'(pending_count) != exp_pending) begin
            report_mismatch("pending_count", int'(pending_count), exp_pending);
        end
        test_num++;
        $display("Test %0d %s: %0d reports, %0d errors", test_num, name,
                 test_reports, test_errors);
        total_reports += test_reports;
        test_reports = 0;
        test_errors  = 0;
    endtask

    task automatic print_totals();
        $display("Totals: %0d tests, %0d reports, %0d errors", test_num,
                 total_reports, error_count);
    endtask

endmodule

`default_nettype wire

/* sim/pkt_monitor_tb.sv */
////////////////////////////////////////////////////////////
// Packet monitor testbench with reference length and CRC
////////////////////////////////////////////////////////////
`default_nettype none

module pkt_monitor_tb import pkt_mon_pkg::*; ();

    localparam int unsigned SEED         = 32'hbeb10e5f;
    localparam int          PERIOD       = 8;
    localparam int          RESET_CYCLES = 16;
    localparam int          NUM_PACKETS  = 19;
    localparam int          MAX_BEATS    = MTU_BYTES / DATA_BYTES;
    // Beats of every packet plus load and drain slack
    localparam int          WATCHDOG_TIME =
        PERIOD * (RESET_CYCLES + NUM_PACKETS * (MAX_BEATS + 40) + 200);

    logic                  axis_packet_in;
    logic                  arst_n;
    logic                  tvalid;
    logic [DATA_W-1:0]     tdata;
    logic [DATA_BYTES-1:0] tkeep;
    logic                  tlast;
    logic [DEST_W-1:0]     tdest;
    logic                  exp_wr;
    logic [EXP_IDX_W-1:0]  exp_index;
    logic [DEST_W-1:0]     exp_dest;
    logic [BLEN_W-1:0]     exp_blen;
    logic [SIG_W-1:0]      exp_sig;
    logic                  match_valid;
    logic                  match_hit;
    logic [EXP_IDX_W-1:0]  match_index;
    logic [DEST_W-1:0]     match_dest;
    logic [BLEN_W-1:0]     match_blen;
    logic [PEND_W-1:0]     pending_count;

    // Packet slots, one per stream in flight
    logic [7:0]        pkt_mem  [NUM_DESTS][MTU_BYTES];
    int                pkt_len  [NUM_DESTS];
    int                pkt_pos  [NUM_DESTS];
    logic [DEST_W-1:0] pkt_dest [NUM_DESTS];

    // Model of the expected table
    logic              mdl_valid [NUM_EXPECTED];
    logic [DEST_W-1:0] mdl_dest  [NUM_EXPECTED];
    logic [BLEN_W-1:0] mdl_blen  [NUM_EXPECTED];
    logic [SIG_W-1:0]  mdl_sig   [NUM_EXPECTED];
    int                mdl_pending;

    tb_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) clk0 (
        .axis_packet_in (axis_packet_in),
        .arst_n         (arst_n)
    );

    pkt_monitor_top dut0 (.*);

    pkt_monitor_checker chk0 (.*);

    ////////////////////////////////////////////////////////////
    // Reference model

    function automatic logic [BLEN_W-1:0] ref_blen(input int slot);
        return BLEN_W'(pkt_len[slot]);
    endfunction

    // Bit-serial CRC-16-CCITT, MSB of each byte first
    function automatic logic [SIG_W-1:0] ref_crc16(input int slot);
        logic [SIG_W-1:0] crc;
        logic             fb;
        crc = SIG_INIT;
        for (int i = 0; i < pkt_len[slot]; i++) begin
            for (int b = 7; b >= 0; b--) begin
                fb  = crc[SIG_W-1] ^ pkt_mem[slot][i][b];
                crc = {crc[SIG_W-2:0], 1'b0};
                if (fb) begin
                    crc = crc ^ SIG_POLY;
                end
            end
        end
        return crc;
    endfunction

    task automatic prepare_packet(input int slot, input int dest, input int len);
        pkt_len[slot]  = len;
        pkt_dest[slot] = DEST_W'(dest);
        for (int i = 0; i < len; i++) begin
            pkt_mem[slot][i] = 8'($urandom);
        end
    endtask

    task automatic load_entry(input int idx, input int slot);
        @(posedge axis_packet_in);
        #1;
        exp_wr    = 1'b1;
        exp_index = EXP_IDX_W'(idx);
        exp_dest  = pkt_dest[slot];
        exp_blen  = ref_blen(slot);
        exp_sig   = ref_crc16(slot);
        if (!mdl_valid[idx]) begin
            mdl_pending++;
        end
        mdl_valid[idx] = 1'b1;
        mdl_dest[idx]  = exp_dest;
        mdl_blen[idx]  = exp_blen;
        mdl_sig[idx]   = exp_sig;
        @(posedge axis_packet_in);
        #1;
        exp_wr = 1'b0;
    endtask

    // Lowest valid matching entry is consumed
    task automatic predict_report(input int slot);
        logic [BLEN_W-1:0] blen;
        logic [SIG_W-1:0]  sig;
        int                idx;
        blen = ref_blen(slot);
        sig  = ref_crc16(slot);
        idx  = -1;
        for (int i = NUM_EXPECTED - 1; i >= 0; i--) begin
            if (mdl_valid[i] && mdl_dest[i] == pkt_dest[slot] &&
                mdl_blen[i] == blen && mdl_sig[i] == sig) begin
                idx = i;
            end
        end
        if (idx >= 0) begin
            mdl_valid[idx] = 1'b0;
            mdl_pending--;
            chk0.expect_report(1'b1, EXP_IDX_W'(idx), pkt_dest[slot], blen);
        end else begin
            chk0.expect_report(1'b0, '0, pkt_dest[slot], blen);
        end
    endtask

    // Round robin over the selected slots, one beat per cycle
    task automatic run_slots(input logic [NUM_DESTS-1:0] mask);
        int remaining;
        int n;
        bit busy;
        for (int s = 0; s < NUM_DESTS; s++) begin
            pkt_pos[s] = mask[s] ? 0 : pkt_len[s];
        end
        busy = 1'b1;
        while (busy) begin
            busy = 1'b0;
            for (int s = 0; s < NUM_DESTS; s++) begin
                remaining = pkt_len[s] - pkt_pos[s];
                if (remaining > 0) begin
                    busy = 1'b1;
                    n    = (remaining < DATA_BYTES) ? remaining : DATA_BYTES;
                    @(posedge axis_packet_in);
                    #1;
                    tvalid = 1'b1;
                    tdest  = pkt_dest[s];
                    tlast  = (remaining == n);
                    for (int l = 0; l < DATA_BYTES; l++) begin
                        tkeep[l] = (l < n);
                        // Lanes outside keep carry junk
                        tdata[l*8 +: 8] = (l < n) ? pkt_mem[s][pkt_pos[s] + l] : 8'($urandom);
                    end
                    pkt_pos[s] += n;
                    if (tlast) begin
                        predict_report(s);
                    end
                end
            end
        end
        @(posedge axis_packet_in);
        #1;
        tvalid = 1'b0;
        tlast  = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        int         pos;
        logic [7:0] saved;
        void'($urandom(SEED));
        tvalid    = 1'b0;
        tdata     = '0;
        tkeep     = '0;
        tlast     = 1'b0;
        tdest     = '0;
        exp_wr    = 1'b0;
        exp_index = '0;
        exp_dest  = '0;
        exp_blen  = '0;
        exp_sig   = '0;
        for (int i = 0; i < NUM_EXPECTED; i++) begin
            mdl_valid[i] = 1'b0;
        end
        mdl_pending = 0;
        wait (arst_n === 1'b1);
        @(posedge axis_packet_in);

        // One packet per destination
        for (int d = 0; d < NUM_DESTS; d++) begin
            prepare_packet(d, d, 1 + int'($urandom % MTU_BYTES));
            load_entry(d, d);
        end
        for (int d = 0; d < NUM_DESTS; d++) begin
            run_slots(NUM_DESTS'(1) << d);
        end
        chk0.close_test("single packet per destination", mdl_pending);

        // Last beat keeps 1 to 4 lanes
        for (int k = 1; k <= DATA_BYTES; k++) begin
            prepare_packet(k - 1, int'($urandom % NUM_DESTS),
                           DATA_BYTES * int'($urandom % MAX_BEATS) + k);
            load_entry(k + 3, k - 1);
        end
        for (int k = 0; k < DATA_BYTES; k++) begin
            run_slots(NUM_DESTS'(1) << k);
        end
        chk0.close_test("last beat keep lanes", mdl_pending);

        // All destinations interleaved beat by beat
        for (int d = 0; d < NUM_DESTS; d++) begin
            prepare_packet(d, NUM_DESTS - 1 - d, 1 + int'($urandom % MTU_BYTES));
            load_entry(NUM_EXPECTED - 1 - d, d);
        end
        run_slots('1);
        chk0.close_test("interleaved destinations", mdl_pending);

        // Corrupted byte, then wrong destination
        prepare_packet(0, 1, 1 + int'($urandom % MTU_BYTES));
        load_entry(0, 0);
        pos   = int'($urandom % pkt_len[0]);
        saved = pkt_mem[0][pos];
        pkt_mem[0][pos] = saved ^ 8'h5a;
        run_slots(4'b0001);
        pkt_mem[0][pos] = saved;
        pkt_dest[0] = 2'd2;
        run_slots(4'b0001);
        pkt_dest[0] = 2'd1;
        chk0.close_test("corrupted byte and wrong destination", mdl_pending);

        // Repeats and duplicate entries
        run_slots(4'b0001);
        run_slots(4'b0001);
        prepare_packet(1, 3, 1 + int'($urandom % MTU_BYTES));
        load_entry(6, 1);
        load_entry(2, 1);
        repeat (3) run_slots(4'b0010);
        chk0.close_test("repeats and duplicate entries", mdl_pending);

        chk0.print_totals();
        if (chk0.error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
hw/pkt_mon_pkg.sv
hw/stream_beat_if.sv
hw/pkt_length_counter.sv
hw/pkt_signature.sv
hw/pkt_matcher.sv
hw/pkt_monitor_top.sv
sim/tb_clock_gen.sv
sim/pkt_monitor_checker.sv
sim/pkt_monitor_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the packet monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module pkt_monitor_tb -f files.f -o sim_pkt_monitor

output=$(./obj_dir/sim_pkt_monitor)
echo "$output"

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
